//--- all.f
src/timestamp_pkg.sv
src/axi_ctrl_slave.sv
src/pixel_domain_sync.sv
src/timestamp_counter.sv
src/master_controller.sv
test/tb_master_controller.sv

//--- src/axi_ctrl_slave.sv
`default_nettype none

module axi_ctrl_slave (
    input  wire                                       s_axi_aclk,
    input  wire                                       s_axi_aresetn,
    // Write address
    input  wire  [timestamp_pkg::AXI_ADDR_WIDTH-1:0]  s_axi_awaddr,
    input  wire                                       s_axi_awvalid,
    output logic                                      s_axi_awready,
    // Write data
    input  wire  [timestamp_pkg::AXI_DATA_WIDTH-1:0]  s_axi_wdata,
    input  wire                                       s_axi_wvalid,
    output logic                                      s_axi_wready,
    // Write response
    output logic [1:0]                                s_axi_bresp,
    output logic                                      s_axi_bvalid,
    input  wire                                       s_axi_bready,
    // Read address
    input  wire  [timestamp_pkg::AXI_ADDR_WIDTH-1:0]  s_axi_araddr,
    input  wire                                       s_axi_arvalid,
    output logic                                      s_axi_arready,
    // Read data
    output logic [timestamp_pkg::AXI_DATA_WIDTH-1:0]  s_axi_rdata,
    output logic [1:0]                                s_axi_rresp,
    output logic                                      s_axi_rvalid,
    input  wire                                       s_axi_rready,
    // Control levels toward the pixel domain
    output logic                                      ctrl_reset,
    output logic                                      ctrl_start,
    output logic                                      ctrl_auto_start,
    output logic [timestamp_pkg::COUNTER_WIDTH-1:0]   offset_value,
    output logic                                      offset_toggle
);

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    logic write_fire;
    logic read_fire;

    // AW and W taken together, only with no response outstanding
    assign s_axi_awready = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
    assign s_axi_wready  = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
    assign write_fire    = s_axi_awready;

    assign s_axi_arready = s_axi_arvalid & ~s_axi_rvalid;
    assign read_fire     = s_axi_arready;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    logic [timestamp_pkg::AXI_ADDR_WIDTH-1:timestamp_pkg::ADDR_LSB] wr_word;
    logic [timestamp_pkg::AXI_ADDR_WIDTH-1:timestamp_pkg::ADDR_LSB] rd_word;
    logic                                        wr_sel_ctrl;
    logic                                        wr_sel_lo;
    logic                                        wr_sel_hi;
    logic                                        wr_sel_load;
    logic                                        wr_mapped;
    logic [timestamp_pkg::AXI_DATA_WIDTH-1:0]    rd_data;
    logic                                        rd_mapped;
    logic [timestamp_pkg::AXI_DATA_WIDTH-1:0]    offset_lo;
    logic [timestamp_pkg::AXI_DATA_WIDTH-1:0]    offset_hi;

    // Word address only, byte lanes ignored
    assign wr_word = s_axi_awaddr[timestamp_pkg::AXI_ADDR_WIDTH-1:timestamp_pkg::ADDR_LSB];
    assign rd_word = s_axi_araddr[timestamp_pkg::AXI_ADDR_WIDTH-1:timestamp_pkg::ADDR_LSB];

    always_comb begin
        wr_sel_ctrl = 1'b0;
        wr_sel_lo   = 1'b0;
        wr_sel_hi   = 1'b0;
        wr_sel_load = 1'b0;
        wr_mapped   = 1'b1;
        case (wr_word)
            timestamp_pkg::REG_CTRL[5:2]:        wr_sel_ctrl = 1'b1;
            timestamp_pkg::REG_OFFSET_LO[5:2]:   wr_sel_lo   = 1'b1;
            timestamp_pkg::REG_OFFSET_HI[5:2]:   wr_sel_hi   = 1'b1;
            timestamp_pkg::REG_OFFSET_LOAD[5:2]: wr_sel_load = 1'b1;
            // Unmapped write has no side effect
            default:                             wr_mapped   = 1'b0;
        endcase
    end

    always_comb begin
        rd_data   = '0;
        rd_mapped = 1'b1;
        case (rd_word)
            timestamp_pkg::REG_CTRL[5:2]: begin
                rd_data[timestamp_pkg::CTRL_RESET_BIT]      = ctrl_reset;
                rd_data[timestamp_pkg::CTRL_START_BIT]      = ctrl_start;
                rd_data[timestamp_pkg::CTRL_AUTO_START_BIT] = ctrl_auto_start;
            end
            timestamp_pkg::REG_OFFSET_LO[5:2]:   rd_data   = offset_lo;
            timestamp_pkg::REG_OFFSET_HI[5:2]:   rd_data   = offset_hi;
            // Load strobe reads as zero
            timestamp_pkg::REG_OFFSET_LOAD[5:2]: rd_data   = '0;
            default:                             rd_mapped = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Control registers and write response
    //////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            // Pixel side comes up held in reset
            ctrl_reset      <= 1'b1;
            ctrl_start      <= 1'b0;
            ctrl_auto_start <= 1'b0;
            offset_toggle   <= 1'b0;
            s_axi_bvalid    <= 1'b0;
        end else if (write_fire) begin
            s_axi_bvalid <= 1'b1;
            if (wr_sel_ctrl) begin
                ctrl_reset      <= s_axi_wdata[timestamp_pkg::CTRL_RESET_BIT];
                ctrl_start      <= s_axi_wdata[timestamp_pkg::CTRL_START_BIT];
                ctrl_auto_start <= s_axi_wdata[timestamp_pkg::CTRL_AUTO_START_BIT];
            end
            // One flip per load request
            if (wr_sel_load) begin
                offset_toggle <= ~offset_toggle;
            end
        end else if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
        end
    end

    // Offset words and response code
    always_ff @(posedge s_axi_aclk) begin
        if (write_fire) begin
            s_axi_bresp <= wr_mapped ? timestamp_pkg::RESP_OKAY : timestamp_pkg::RESP_SLVERR;
            if (wr_sel_lo) begin
                offset_lo <= s_axi_wdata;
            end
            if (wr_sel_hi) begin
                offset_hi <= s_axi_wdata;
            end
        end
    end

    assign offset_value = {offset_hi, offset_lo};

    //////////////////////////////////////////////////
    // Read response
    //////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_rvalid <= 1'b0;
        end else if (read_fire) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    // Data held stable until rready
    always_ff @(posedge s_axi_aclk) begin
        if (read_fire) begin
            s_axi_rdata <= rd_data;
            s_axi_rresp <= rd_mapped ? timestamp_pkg::RESP_OKAY : timestamp_pkg::RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

//--- src/master_controller.sv
`default_nettype none

module master_controller (
    // Bus clock and reset
    input  wire                                      s_axi_aclk,
    input  wire                                      s_axi_aresetn,
    // Write address
    input  wire  [timestamp_pkg::AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  wire                                      s_axi_awvalid,
    output wire                                      s_axi_awready,
    // Write data
    input  wire  [timestamp_pkg::AXI_DATA_WIDTH-1:0] s_axi_wdata,
    input  wire                                      s_axi_wvalid,
    output wire                                      s_axi_wready,
    // Write response
    output wire  [1:0]                               s_axi_bresp,
    output wire                                      s_axi_bvalid,
    input  wire                                      s_axi_bready,
    // Read address
    input  wire  [timestamp_pkg::AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  wire                                      s_axi_arvalid,
    output wire                                      s_axi_arready,
    // Read data
    output wire  [timestamp_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
    output wire  [1:0]                               s_axi_rresp,
    output wire                                      s_axi_rvalid,
    input  wire                                      s_axi_rready,
    // Timestamp side
    input  wire                                      clk_pixel,
    output wire                                      auto_start,
    output wire  [timestamp_pkg::COUNTER_WIDTH-1:0]  counter,
    output wire                                      pixel_clk_resetn
);

    //////////////////////////////////////////////////
    // Bus domain
    //////////////////////////////////////////////////

    wire                                     ctrl_reset;
    wire                                     ctrl_start;
    wire                                     ctrl_auto_start;
    wire [timestamp_pkg::COUNTER_WIDTH-1:0]  offset_value;
    wire                                     offset_toggle;

    // Pixel domain
    wire                                     reset_buffer2;
    wire                                     start_sync;
    wire                                     offset_load;
    wire [timestamp_pkg::COUNTER_WIDTH-1:0]  counter_offset;

    axi_ctrl_slave u_axi_ctrl_slave (
        .s_axi_aclk      (s_axi_aclk),
        .s_axi_aresetn   (s_axi_aresetn),
        .s_axi_awaddr    (s_axi_awaddr),
        .s_axi_awvalid   (s_axi_awvalid),
        .s_axi_awready   (s_axi_awready),
        .s_axi_wdata     (s_axi_wdata),
        .s_axi_wvalid    (s_axi_wvalid),
        .s_axi_wready    (s_axi_wready),
        .s_axi_bresp     (s_axi_bresp),
        .s_axi_bvalid    (s_axi_bvalid),
        .s_axi_bready    (s_axi_bready),
        .s_axi_araddr    (s_axi_araddr),
        .s_axi_arvalid   (s_axi_arvalid),
        .s_axi_arready   (s_axi_arready),
        .s_axi_rdata     (s_axi_rdata),
        .s_axi_rresp     (s_axi_rresp),
        .s_axi_rvalid    (s_axi_rvalid),
        .s_axi_rready    (s_axi_rready),
        .ctrl_reset      (ctrl_reset),
        .ctrl_start      (ctrl_start),
        .ctrl_auto_start (ctrl_auto_start),
        .offset_value    (offset_value),
        .offset_toggle   (offset_toggle)
    );

    //////////////////////////////////////////////////
    // Crossing into clk_pixel
    //////////////////////////////////////////////////

    pixel_domain_sync u_pixel_domain_sync (
        .clk_pixel       (clk_pixel),
        .ctrl_reset      (ctrl_reset),
        .ctrl_start      (ctrl_start),
        .ctrl_auto_start (ctrl_auto_start),
        .offset_value    (offset_value),
        .offset_toggle   (offset_toggle),
        .reset_buffer2   (reset_buffer2),
        .start_sync      (start_sync),
        .auto_start      (auto_start),
        .offset_load     (offset_load),
        .counter_offset  (counter_offset)
    );

    timestamp_counter u_timestamp_counter (
        .clk_pixel      (clk_pixel),
        .reset_buffer2  (reset_buffer2),
        .start_sync     (start_sync),
        .offset_load    (offset_load),
        .counter_offset (counter_offset),
        .counter        (counter)
    );

    // Active low copy for the pixel pipeline
    assign pixel_clk_resetn = ~reset_buffer2;

endmodule

`default_nettype wire

//--- src/pixel_domain_sync.sv
`default_nettype none

module pixel_domain_sync (
    input  wire                                      clk_pixel,
    // Bus domain levels
    input  wire                                      ctrl_reset,
    input  wire                                      ctrl_start,
    input  wire                                      ctrl_auto_start,
    input  wire  [timestamp_pkg::COUNTER_WIDTH-1:0]  offset_value,
    input  wire                                      offset_toggle,
    // Pixel domain results
    output logic                                     reset_buffer2,
    output logic                                     start_sync,
    output logic                                     auto_start,
    output logic                                     offset_load,
    output logic [timestamp_pkg::COUNTER_WIDTH-1:0]  counter_offset
);

    //////////////////////////////////////////////////
    // Level synchronizers
    //////////////////////////////////////////////////

    // Index 0 samples the bus domain
    logic [timestamp_pkg::SYNC_STAGES-1:0] reset_chain;
    logic [timestamp_pkg::SYNC_STAGES-1:0] start_chain;
    logic [timestamp_pkg::SYNC_STAGES-1:0] auto_chain;

    // No reset on these flops
    always_ff @(posedge clk_pixel) begin
        reset_chain <= {reset_chain[timestamp_pkg::SYNC_STAGES-2:0], ctrl_reset};
        start_chain <= {start_chain[timestamp_pkg::SYNC_STAGES-2:0], ctrl_start};
        auto_chain  <= {auto_chain[timestamp_pkg::SYNC_STAGES-2:0], ctrl_auto_start};
    end

    assign reset_buffer2 = reset_chain[timestamp_pkg::SYNC_STAGES-1];
    assign start_sync    = start_chain[timestamp_pkg::SYNC_STAGES-1];
    assign auto_start    = auto_chain[timestamp_pkg::SYNC_STAGES-1];

    //////////////////////////////////////////////////
    // Offset transfer
    //////////////////////////////////////////////////

    // Two sync stages plus one for edge detection
    logic [timestamp_pkg::SYNC_STAGES:0] toggle_chain;
    logic                                toggle_edge;

    always_ff @(posedge clk_pixel) begin
        toggle_chain <= {toggle_chain[timestamp_pkg::SYNC_STAGES-1:0], offset_toggle};
    end

    // Last stage against the one before it
    assign toggle_edge = toggle_chain[timestamp_pkg::SYNC_STAGES]
                       ^ toggle_chain[timestamp_pkg::SYNC_STAGES-1];

    // Single cycle load request
    always_ff @(posedge clk_pixel) begin
        if (reset_buffer2) begin
            offset_load <= 1'b0;
        end else begin
            offset_load <= toggle_edge;
        end
    end

    // Offset bus is quiet by now
    // Software holds the offset words until the load lands
    always_ff @(posedge clk_pixel) begin
        if (toggle_edge) begin
            counter_offset <= offset_value;
        end
    end

endmodule

`default_nettype wire

//--- src/timestamp_counter.sv
`default_nettype none

module timestamp_counter (
    input  wire                                      clk_pixel,
    input  wire                                      reset_buffer2,
    input  wire                                      start_sync,
    input  wire                                      offset_load,
    input  wire  [timestamp_pkg::COUNTER_WIDTH-1:0]  counter_offset,
    output logic [timestamp_pkg::COUNTER_WIDTH-1:0]  counter
);

    //////////////////////////////////////////////////
    // Running count
    //////////////////////////////////////////////////

    logic [timestamp_pkg::COUNTER_WIDTH-1:0] count;

    // Reset first, then load, then count
    always_ff @(posedge clk_pixel) begin
        if (reset_buffer2) begin
            count <= '0;
        end else if (offset_load) begin
            count <= counter_offset;
        end else if (start_sync) begin
            count <= count + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    // One cycle behind the count
    always_ff @(posedge clk_pixel) begin
        if (reset_buffer2) begin
            counter <= '0;
        end else begin
            counter <= count;
        end
    end

endmodule

`default_nettype wire

//--- src/timestamp_pkg.sv
`default_nettype none

package timestamp_pkg;

    //////////////////////////////////////////////////
    // Bus geometry
    //////////////////////////////////////////////////

    localparam int AXI_ADDR_WIDTH = 6;
    localparam int AXI_DATA_WIDTH = 32;
    // Byte offset bits below the word address
    localparam int ADDR_LSB = 2;

    //////////////////////////////////////////////////
    // Timestamp domain
    //////////////////////////////////////////////////

    localparam int COUNTER_WIDTH = 64;
    // Flops per level synchronizer into clk_pixel
    localparam int SYNC_STAGES = 2;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    localparam logic [AXI_ADDR_WIDTH-1:0] REG_CTRL        = 6'h00;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_OFFSET_LO   = 6'h04;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_OFFSET_HI   = 6'h08;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_OFFSET_LOAD = 6'h0C;

    // Control register bit positions
    localparam int CTRL_RESET_BIT      = 0;
    localparam int CTRL_START_BIT      = 1;
    localparam int CTRL_AUTO_START_BIT = 2;

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- test/tb_master_controller.sv
`default_nettype none

module tb_master_controller;

    localparam int DRIVE_DELAY   = 1;
    localparam int BUS_TIMEOUT   = 20;
    localparam int PIXEL_TIMEOUT = 10 * timestamp_pkg::SYNC_STAGES;
    // Which pixel side output a poll watches
    localparam int SEL_AUTO_START = 0;
    localparam int SEL_RESETN     = 1;
    localparam int SEL_COUNTER    = 2;

    logic                                     s_axi_aclk;
    logic                                     s_axi_aresetn;
    logic [timestamp_pkg::AXI_ADDR_WIDTH-1:0] s_axi_awaddr;
    logic                                     s_axi_awvalid;
    wire                                      s_axi_awready;
    logic [timestamp_pkg::AXI_DATA_WIDTH-1:0] s_axi_wdata;
    logic                                     s_axi_wvalid;
    wire                                      s_axi_wready;
    wire  [1:0]                               s_axi_bresp;
    wire                                      s_axi_bvalid;
    logic                                     s_axi_bready;
    logic [timestamp_pkg::AXI_ADDR_WIDTH-1:0] s_axi_araddr;
    logic                                     s_axi_arvalid;
    wire                                      s_axi_arready;
    wire  [timestamp_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata;
    wire  [1:0]                               s_axi_rresp;
    wire                                      s_axi_rvalid;
    logic                                     s_axi_rready;
    logic                                     clk_pixel;
    wire                                      auto_start;
    wire  [timestamp_pkg::COUNTER_WIDTH-1:0]  counter;
    wire                                      pixel_clk_resetn;

    // Bookkeeping
    string       test_name;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          errors_before;
    logic [31:0] lfsr_state = 32'h3ffc_2fc8;
    logic [63:0] saved_lo;

    master_controller uut (.*);

    initial begin
        clk_pixel = 1'b0;
        forever #5 clk_pixel = ~clk_pixel;
    end

    initial begin
        s_axi_aclk = 1'b0;
        forever #7 s_axi_aclk = ~s_axi_aclk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic random_bits(input int width, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            value      = {value[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        error_count++;
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        $display("Test %s finished with %0d errors", test_name, error_count - errors_before);
    endtask

    // Pixel outputs are settled just after the edge
    task automatic next_pixel_sample();
        @(posedge clk_pixel);
        #DRIVE_DELAY;
    endtask

    task automatic wait_pixel_output(input string what, input int sel,
                                     input logic [63:0] expected);
        int          waited;
        logic [63:0] seen;
        waited = 0;
        seen   = ~expected;
        while (seen !== expected && waited < PIXEL_TIMEOUT) begin
            next_pixel_sample();
            if (sel == SEL_AUTO_START) begin
                seen = {63'd0, auto_start};
            end else if (sel == SEL_RESETN) begin
                seen = {63'd0, pixel_clk_resetn};
            end else begin
                seen = counter;
            end
            waited++;
        end
        if (seen !== expected) begin
            report_timeout(what);
        end
    endtask

    // Low for exactly four bus edges
    task automatic apply_bus_reset();
        s_axi_aresetn = 1'b0;
        repeat (4) @(posedge s_axi_aclk);
        #DRIVE_DELAY;
        s_axi_aresetn = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////

    task automatic axi_write(input logic [5:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        @(posedge s_axi_aclk);
        #DRIVE_DELAY;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        waited = 0;
        // Both readys are combinational and settle one unit after driving
        #DRIVE_DELAY;
        while (!(s_axi_awready && s_axi_wready) && waited < BUS_TIMEOUT) begin
            @(posedge s_axi_aclk);
            #(2 * DRIVE_DELAY);
            waited++;
        end
        if (!s_axi_awready) begin
            report_timeout("awready");
        end
        if (!s_axi_wready) begin
            report_timeout("wready");
        end
        @(posedge s_axi_aclk);
        #DRIVE_DELAY;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        waited = 0;
        while (!s_axi_bvalid && waited < BUS_TIMEOUT) begin
            @(posedge s_axi_aclk);
            #DRIVE_DELAY;
            waited++;
        end
        if (!s_axi_bvalid) begin
            report_timeout("bvalid");
        end
        resp = s_axi_bresp;
        @(posedge s_axi_aclk);
        #DRIVE_DELAY;
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [5:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int waited;
        @(posedge s_axi_aclk);
        #DRIVE_DELAY;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        waited = 0;
        #DRIVE_DELAY;
        while (!s_axi_arready && waited < BUS_TIMEOUT) begin
            @(posedge s_axi_aclk);
            #(2 * DRIVE_DELAY);
            waited++;
        end
        if (!s_axi_arready) begin
            report_timeout("arready");
        end
        @(posedge s_axi_aclk);
        #DRIVE_DELAY;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        waited = 0;
        while (!s_axi_rvalid && waited < BUS_TIMEOUT) begin
            @(posedge s_axi_aclk);
            #DRIVE_DELAY;
            waited++;
        end
        if (!s_axi_rvalid) begin
            report_timeout("rvalid");
        end
        data = s_axi_rdata;
        resp = s_axi_rresp;
        @(posedge s_axi_aclk);
        #DRIVE_DELAY;
        s_axi_rready = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic register_readback();
        logic [1:0]  resp;
        logic [31:0] data;
        logic [63:0] hi;
        logic [63:0] ctrl;
        begin_test("register_readback");
        random_bits(32, saved_lo);
        random_bits(32, hi);
        random_bits(3, ctrl);
        axi_write(timestamp_pkg::REG_OFFSET_LO, saved_lo[31:0], resp);
        compare("lo write resp", timestamp_pkg::RESP_OKAY, resp);
        axi_write(timestamp_pkg::REG_OFFSET_HI, hi[31:0], resp);
        compare("hi write resp", timestamp_pkg::RESP_OKAY, resp);
        axi_write(timestamp_pkg::REG_CTRL, ctrl[31:0], resp);
        compare("ctrl write resp", timestamp_pkg::RESP_OKAY, resp);
        axi_read(timestamp_pkg::REG_OFFSET_LO, data, resp);
        compare("lo data", saved_lo, data);
        compare("lo read resp", timestamp_pkg::RESP_OKAY, resp);
        axi_read(timestamp_pkg::REG_OFFSET_HI, data, resp);
        compare("hi data", hi, data);
        compare("hi read resp", timestamp_pkg::RESP_OKAY, resp);
        axi_read(timestamp_pkg::REG_CTRL, data, resp);
        compare("ctrl data", ctrl, data);
        compare("ctrl read resp", timestamp_pkg::RESP_OKAY, resp);
        // Load strobe is write only
        axi_read(timestamp_pkg::REG_OFFSET_LOAD, data, resp);
        compare("load data", 64'd0, data);
        compare("load read resp", timestamp_pkg::RESP_OKAY, resp);
        end_test();
    endtask

    task automatic unmapped_address();
        logic [1:0]  resp;
        logic [31:0] data;
        logic [63:0] junk;
        begin_test("unmapped_address");
        random_bits(32, junk);
        axi_write(6'h20, junk[31:0], resp);
        compare("write resp", timestamp_pkg::RESP_SLVERR, resp);
        axi_read(6'h20, data, resp);
        compare("read resp", timestamp_pkg::RESP_SLVERR, resp);
        axi_read(timestamp_pkg::REG_OFFSET_LO, data, resp);
        compare("lo unchanged", saved_lo, data);
        end_test();
    endtask

    task automatic reset_and_auto_start();
        logic [1:0] resp;
        begin_test("reset_and_auto_start");
        apply_bus_reset();
        // Pixel side held in reset straight out of bus reset
        compare("resetn after reset", 64'd0, pixel_clk_resetn);
        compare("counter after reset", 64'd0, counter);
        axi_write(timestamp_pkg::REG_CTRL, 1 << timestamp_pkg::CTRL_AUTO_START_BIT, resp);
        wait_pixel_output("auto_start high", SEL_AUTO_START, 64'd1);
        wait_pixel_output("pixel_clk_resetn high", SEL_RESETN, 64'd1);
        axi_write(timestamp_pkg::REG_CTRL, 32'd0, resp);
        wait_pixel_output("auto_start low", SEL_AUTO_START, 64'd0);
        end_test();
    endtask

    task automatic counting_run();
        logic [1:0]  resp;
        logic [63:0] prev;
        logic        stopped;
        int          waited;
        begin_test("counting");
        axi_write(timestamp_pkg::REG_CTRL, 1 << timestamp_pkg::CTRL_START_BIT, resp);
        prev   = '0;
        waited = 0;
        while (prev == 0 && waited < PIXEL_TIMEOUT) begin
            next_pixel_sample();
            prev = counter;
            waited++;
        end
        if (prev == 0) begin
            report_timeout("counter to leave zero");
        end
        repeat (16) begin
            next_pixel_sample();
            compare("increment", prev + 1, counter);
            prev = counter;
        end
        axi_write(timestamp_pkg::REG_CTRL, 32'd0, resp);
        // Two equal samples in a row mean the count stopped
        stopped = 1'b0;
        waited  = 0;
        while (!stopped && waited < PIXEL_TIMEOUT) begin
            prev = counter;
            next_pixel_sample();
            stopped = (counter == prev);
            waited++;
        end
        if (!stopped) begin
            report_timeout("counter to stop");
        end
        repeat (10) begin
            next_pixel_sample();
            compare("hold", prev, counter);
        end
        end_test();
    endtask

    task automatic load_offset();
        logic [1:0]  resp;
        logic [63:0] offset;
        logic [63:0] junk;
        begin_test("offset_load");
        random_bits(64, offset);
        axi_write(timestamp_pkg::REG_OFFSET_LO, offset[31:0], resp);
        axi_write(timestamp_pkg::REG_OFFSET_HI, offset[63:32], resp);
        random_bits(32, junk);
        axi_write(timestamp_pkg::REG_OFFSET_LOAD, junk[31:0], resp);
        wait_pixel_output("counter at offset", SEL_COUNTER, offset);
        axi_write(timestamp_pkg::REG_CTRL, 1 << timestamp_pkg::CTRL_START_BIT, resp);
        wait_pixel_output("counter past offset", SEL_COUNTER, offset + 1);
        end_test();
    endtask

    task automatic soft_reset();
        logic [1:0] resp;
        begin_test("soft_reset");
        axi_write(timestamp_pkg::REG_CTRL, 1 << timestamp_pkg::CTRL_RESET_BIT, resp);
        wait_pixel_output("pixel_clk_resetn low", SEL_RESETN, 64'd0);
        wait_pixel_output("counter cleared", SEL_COUNTER, 64'd0);
        end_test();
    endtask

    initial begin
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        apply_bus_reset();
        register_readback();
        unmapped_address();
        reset_and_auto_start();
        counting_run();
        load_offset();
        soft_reset();
        $display("Tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
